/* eth_switch_pkg.sv */
package eth_switch_pkg;

	// Switch geometry
	localparam int N_PORTS  = 4;
	localparam int LG_PORTS = 2;

	// Stream and address widths
	localparam int BEAT_W = 64;
	localparam int MAC_W  = 48;

	// Storage depths, as log2
	localparam int LG_TBL  = 3;
	localparam int FIFO_LG = 4;

	// First byte on the wire sits in the top bits
	typedef logic [BEAT_W-1:0] beat_t;

	// Valid bytes in a beat, zero means a full beat
	typedef logic [$clog2(BEAT_W/8)-1:0] bytes_t;

	typedef logic [MAC_W-1:0] mac_t;

	// One bit per port
	typedef logic [N_PORTS-1:0] port_mask_t;

	typedef logic [LG_PORTS-1:0] port_id_t;

endpackage

/* rx_src_mac.sv */
`timescale 1ns/1ps

module rx_src_mac #(
	parameter int P_PORT = 0
) (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_valid,
	output logic                   o_ready,
	input  eth_switch_pkg::beat_t  i_data,
	input  eth_switch_pkg::bytes_t i_bytes,
	input  logic                   i_last,
	output logic                   o_valid,
	input  logic                   i_ready,
	output eth_switch_pkg::beat_t  o_data,
	output eth_switch_pkg::bytes_t o_bytes,
	output logic                   o_last,
	output logic                   o_learn,
	output eth_switch_pkg::mac_t   o_learn_mac
);
	import eth_switch_pkg::*;

	logic [1:0]  beat_pos;
	logic [15:0] mac_hi;
	logic        xfer;

	// The learn slot in the top-level vector tags the port
	if (P_PORT >= N_PORTS) begin : g_port_check
		$error("rx_src_mac P_PORT out of range");
	end

	// Stream passes straight through
	assign o_valid = i_valid;
	assign o_ready = i_ready;
	assign o_data  = i_data;
	assign o_bytes = i_bytes;
	assign o_last  = i_last;

	assign xfer = i_valid && i_ready;

	// Beat position, saturates at 2 until LAST
	always_ff @(posedge i_clk) begin
		if (i_reset)
			beat_pos <= 2'd0;
		else if (xfer) begin
			if (i_last)
				beat_pos <= 2'd0;
			else if (beat_pos != 2'd2)
				beat_pos <= beat_pos + 2'd1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset)
			o_learn <= 1'b0;
		else
			o_learn <= xfer && (beat_pos == 2'd1);
	end

	// Source MAC straddles beats 0 and 1
	always_ff @(posedge i_clk) begin
		if (xfer && beat_pos == 2'd0)
			mac_hi <= i_data[15:0];
		if (xfer && beat_pos == 2'd1)
			o_learn_mac <= {mac_hi, i_data[63:32]};
	end

endmodule

/* pkt_fifo.sv */
`timescale 1ns/1ps

module pkt_fifo (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_valid,
	output logic                   o_ready,
	input  eth_switch_pkg::beat_t  i_data,
	input  eth_switch_pkg::bytes_t i_bytes,
	input  logic                   i_last,
	output logic                   o_valid,
	input  logic                   i_ready,
	output eth_switch_pkg::beat_t  o_data,
	output eth_switch_pkg::bytes_t o_bytes,
	output logic                   o_last
);
	import eth_switch_pkg::*;

	beat_t  mem_data  [2**FIFO_LG];
	bytes_t mem_bytes [2**FIFO_LG];
	logic   mem_last  [2**FIFO_LG];

	logic [FIFO_LG-1:0] wr_ptr, rd_ptr;
	logic [FIFO_LG:0]   fill;
	logic               do_wr, do_rd;

	// Top bit of the count is set only when full
	assign o_ready = !fill[FIFO_LG];
	assign o_valid = (fill != '0);
	assign do_wr = i_valid && o_ready;
	assign do_rd = o_valid && i_ready;

	assign o_data  = mem_data[rd_ptr];
	assign o_bytes = mem_bytes[rd_ptr];
	assign o_last  = mem_last[rd_ptr];

	always_ff @(posedge i_clk) begin
		if (do_wr) begin
			mem_data[wr_ptr]  <= i_data;
			mem_bytes[wr_ptr] <= i_bytes;
			mem_last[wr_ptr]  <= i_last;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

endmodule

/* route_table.sv */
`timescale 1ns/1ps

module route_table (
	input  logic                       i_clk,
	input  logic                       i_reset,
	input  eth_switch_pkg::port_mask_t i_learn,
	input  eth_switch_pkg::mac_t       i_learn_mac [eth_switch_pkg::N_PORTS],
	input  eth_switch_pkg::port_mask_t i_lookup,
	input  eth_switch_pkg::mac_t       i_lookup_mac [eth_switch_pkg::N_PORTS],
	output eth_switch_pkg::port_mask_t o_lookup_valid,
	output eth_switch_pkg::port_mask_t o_lookup_mask [eth_switch_pkg::N_PORTS]
);
	import eth_switch_pkg::*;

	mac_t                 tbl_mac  [2**LG_TBL];
	port_id_t             tbl_port [2**LG_TBL];
	logic [2**LG_TBL-1:0] tbl_vld;
	logic [LG_TBL-1:0]    wr_ptr;

	mac_t                 nxt_mac  [2**LG_TBL];
	port_id_t             nxt_port [2**LG_TBL];
	logic [2**LG_TBL-1:0] nxt_vld;
	logic [LG_TBL-1:0]    nxt_ptr;
	logic                 seen;

	////////////////////////////////////////////////////////////
	// Learn path
	////////////////////////////////////////////////////////////

	// Ports are applied in order, each one sees the earlier ones
	always_comb begin
		nxt_mac  = tbl_mac;
		nxt_port = tbl_port;
		nxt_vld  = tbl_vld;
		nxt_ptr  = wr_ptr;
		for (int p = 0; p < N_PORTS; p++) begin
			seen = 1'b0;
			if (i_learn[p]) begin
				for (int e = 0; e < 2**LG_TBL; e++) begin
					if (nxt_vld[e] && nxt_mac[e] == i_learn_mac[p]) begin
						nxt_port[e] = port_id_t'(p);
						seen = 1'b1;
					end
				end
				// New station takes the round-robin slot
				if (!seen) begin
					nxt_mac[nxt_ptr]  = i_learn_mac[p];
					nxt_port[nxt_ptr] = port_id_t'(p);
					nxt_vld[nxt_ptr]  = 1'b1;
					nxt_ptr = nxt_ptr + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		tbl_mac  <= nxt_mac;
		tbl_port <= nxt_port;
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			tbl_vld <= '0;
			wr_ptr  <= '0;
		end else begin
			tbl_vld <= nxt_vld;
			wr_ptr  <= nxt_ptr;
		end
	end

	////////////////////////////////////////////////////////////
	// Lookup path
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset)
			o_lookup_valid <= '0;
		else
			o_lookup_valid <= i_lookup;
	end

	// Miss floods to all ports
	always_ff @(posedge i_clk) begin
		for (int p = 0; p < N_PORTS; p++) begin
			o_lookup_mask[p] <= '1;
			for (int e = 0; e < 2**LG_TBL; e++) begin
				if (tbl_vld[e] && tbl_mac[e] == i_lookup_mac[p])
					o_lookup_mask[p] <= port_mask_t'(1) << tbl_port[e];
			end
		end
	end

endmodule

/* tx_dst_lookup.sv */
`timescale 1ns/1ps

module tx_dst_lookup #(
	parameter int P_PORT = 0
) (
	input  logic                       i_clk,
	input  logic                       i_reset,
	input  logic                       i_valid,
	output logic                       o_ready,
	input  eth_switch_pkg::beat_t      i_data,
	input  eth_switch_pkg::bytes_t     i_bytes,
	input  logic                       i_last,
	output logic                       o_lookup,
	output eth_switch_pkg::mac_t       o_lookup_mac,
	input  logic                       i_lookup_valid,
	input  eth_switch_pkg::port_mask_t i_lookup_mask,
	output eth_switch_pkg::port_mask_t o_valid,
	input  eth_switch_pkg::port_mask_t i_ready,
	output eth_switch_pkg::beat_t      o_data,
	output eth_switch_pkg::bytes_t     o_bytes,
	output logic                       o_last
);
	import eth_switch_pkg::*;

	typedef enum logic [1:0] {IDLE, LOOKUP, WAIT, SEND} state_t;

	state_t     state;
	port_mask_t own_bit, tgt, owed, low_owed, taken;
	logic       first_beat, beat_done;

	assign own_bit = port_mask_t'(1) << P_PORT;

	// Destination MAC sits at the top of beat 0
	assign o_lookup     = (state == LOOKUP);
	assign o_lookup_mac = i_data[BEAT_W-1 -: MAC_W];

	// Beat 0 claims its outputs lowest first, so two multicast
	// frames can never each hold an arbiter the other one needs
	assign low_owed = owed & (~owed + 1'b1);
	assign o_valid = (state == SEND && i_valid) ? (first_beat ? low_owed : owed) : '0;
	assign taken = o_valid & i_ready;
	assign beat_done = ((owed & ~taken) == '0);

	// An empty target mask drains the frame
	assign o_ready = (state == SEND) && i_valid && beat_done;

	assign o_data  = i_data;
	assign o_bytes = i_bytes;
	assign o_last  = i_last;

	always_ff @(posedge i_clk) begin
		if (state == WAIT && i_lookup_valid)
			tgt <= i_lookup_mask & ~own_bit;
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state      <= IDLE;
			owed       <= '0;
			first_beat <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (i_valid)
						state <= LOOKUP;
				end
				LOOKUP: begin
					state <= WAIT;
				end
				WAIT: begin
					if (i_lookup_valid) begin
						state      <= SEND;
						owed       <= i_lookup_mask & ~own_bit;
						first_beat <= 1'b1;
					end
				end
				SEND: begin
					if (o_ready) begin
						owed       <= tgt;
						first_beat <= 1'b0;
						if (i_last)
							state <= IDLE;
					end else begin
						owed <= owed & ~taken;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* tx_arbiter.sv */
`timescale 1ns/1ps

module tx_arbiter (
	input  logic                       i_clk,
	input  logic                       i_reset,
	input  eth_switch_pkg::port_mask_t i_valid,
	output eth_switch_pkg::port_mask_t o_ready,
	input  eth_switch_pkg::beat_t      i_data  [eth_switch_pkg::N_PORTS],
	input  eth_switch_pkg::bytes_t     i_bytes [eth_switch_pkg::N_PORTS],
	input  eth_switch_pkg::port_mask_t i_last,
	output logic                       o_valid,
	input  logic                       i_ready,
	output eth_switch_pkg::beat_t      o_data,
	output eth_switch_pkg::bytes_t     o_bytes,
	output logic                       o_last
);
	import eth_switch_pkg::*;

	port_id_t grant, pick, idx;
	logic     locked, any_req;

	// Search downward so the nearest requester after grant wins
	always_comb begin
		pick    = grant;
		any_req = 1'b0;
		for (int k = N_PORTS; k >= 1; k--) begin
			idx = grant + port_id_t'(k);
			if (i_valid[idx]) begin
				pick    = idx;
				any_req = 1'b1;
			end
		end
	end

	// Held from grant through the LAST beat
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			grant  <= port_id_t'(N_PORTS - 1);
			locked <= 1'b0;
		end else if (!locked) begin
			if (any_req) begin
				grant  <= pick;
				locked <= 1'b1;
			end
		end else if (o_valid && i_ready && o_last) begin
			locked <= 1'b0;
		end
	end

	assign o_valid = locked && i_valid[grant];
	assign o_data  = i_data[grant];
	assign o_bytes = i_bytes[grant];
	assign o_last  = i_last[grant];

	always_comb begin
		o_ready = '0;
		o_ready[grant] = locked && i_ready;
	end

endmodule

/* switch_top.sv */
`timescale 1ns/1ps

module switch_top (
	input  logic                       i_clk,
	input  logic                       i_reset,
	input  eth_switch_pkg::port_mask_t i_rx_valid,
	output eth_switch_pkg::port_mask_t o_rx_ready,
	input  eth_switch_pkg::beat_t      i_rx_data  [eth_switch_pkg::N_PORTS],
	input  eth_switch_pkg::bytes_t     i_rx_bytes [eth_switch_pkg::N_PORTS],
	input  eth_switch_pkg::port_mask_t i_rx_last,
	output eth_switch_pkg::port_mask_t o_tx_valid,
	input  eth_switch_pkg::port_mask_t i_tx_ready,
	output eth_switch_pkg::beat_t      o_tx_data  [eth_switch_pkg::N_PORTS],
	output eth_switch_pkg::bytes_t     o_tx_bytes [eth_switch_pkg::N_PORTS],
	output eth_switch_pkg::port_mask_t o_tx_last
);
	import eth_switch_pkg::*;

	// Source-MAC stage into the FIFO
	port_mask_t sm_valid, sm_ready, sm_last;
	beat_t      sm_data  [N_PORTS];
	bytes_t     sm_bytes [N_PORTS];

	// FIFO into the lookup stage
	port_mask_t fq_valid, fq_ready, fq_last;
	beat_t      fq_data  [N_PORTS];
	bytes_t     fq_bytes [N_PORTS];

	// Table strobes
	port_mask_t learn, lookup, lookup_valid;
	mac_t       learn_mac   [N_PORTS];
	mac_t       lookup_mac  [N_PORTS];
	port_mask_t lookup_mask [N_PORTS];

	// Fan-out indexed by source, then by output
	port_mask_t fan_valid [N_PORTS];
	port_mask_t fan_ready [N_PORTS];
	beat_t      fan_data  [N_PORTS];
	bytes_t     fan_bytes [N_PORTS];
	port_mask_t fan_last;

	// Same handshakes indexed by output, then by source
	port_mask_t arb_valid [N_PORTS];
	port_mask_t arb_ready [N_PORTS];

	////////////////////////////////////////////////////////////
	// Per-port pipelines
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < N_PORTS; g++) begin : g_port
		rx_src_mac #(.P_PORT(g)) rx_src_mac_i (
			.i_clk(i_clk), .i_reset(i_reset),
			.i_valid(i_rx_valid[g]), .o_ready(o_rx_ready[g]),
			.i_data(i_rx_data[g]), .i_bytes(i_rx_bytes[g]), .i_last(i_rx_last[g]),
			.o_valid(sm_valid[g]), .i_ready(sm_ready[g]),
			.o_data(sm_data[g]), .o_bytes(sm_bytes[g]), .o_last(sm_last[g]),
			.o_learn(learn[g]), .o_learn_mac(learn_mac[g])
		);

		pkt_fifo pkt_fifo_i (
			.i_clk(i_clk), .i_reset(i_reset),
			.i_valid(sm_valid[g]), .o_ready(sm_ready[g]),
			.i_data(sm_data[g]), .i_bytes(sm_bytes[g]), .i_last(sm_last[g]),
			.o_valid(fq_valid[g]), .i_ready(fq_ready[g]),
			.o_data(fq_data[g]), .o_bytes(fq_bytes[g]), .o_last(fq_last[g])
		);

		tx_dst_lookup #(.P_PORT(g)) tx_dst_lookup_i (
			.i_clk(i_clk), .i_reset(i_reset),
			.i_valid(fq_valid[g]), .o_ready(fq_ready[g]),
			.i_data(fq_data[g]), .i_bytes(fq_bytes[g]), .i_last(fq_last[g]),
			.o_lookup(lookup[g]), .o_lookup_mac(lookup_mac[g]),
			.i_lookup_valid(lookup_valid[g]), .i_lookup_mask(lookup_mask[g]),
			.o_valid(fan_valid[g]), .i_ready(fan_ready[g]),
			.o_data(fan_data[g]), .o_bytes(fan_bytes[g]), .o_last(fan_last[g])
		);

		// Output g sees every source, including its own idle one
		tx_arbiter tx_arbiter_i (
			.i_clk(i_clk), .i_reset(i_reset),
			.i_valid(arb_valid[g]), .o_ready(arb_ready[g]),
			.i_data(fan_data), .i_bytes(fan_bytes), .i_last(fan_last),
			.o_valid(o_tx_valid[g]), .i_ready(i_tx_ready[g]),
			.o_data(o_tx_data[g]), .o_bytes(o_tx_bytes[g]), .o_last(o_tx_last[g])
		);
	end

	// Transpose the handshake matrix
	for (genvar s = 0; s < N_PORTS; s++) begin : g_xpose_src
		for (genvar o = 0; o < N_PORTS; o++) begin : g_xpose_out
			assign arb_valid[o][s] = fan_valid[s][o];
			assign fan_ready[s][o] = arb_ready[o][s];
		end
	end

	route_table route_table_i (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_learn(learn), .i_learn_mac(learn_mac),
		.i_lookup(lookup), .i_lookup_mac(lookup_mac),
		.o_lookup_valid(lookup_valid), .o_lookup_mask(lookup_mask)
	);

endmodule

/* switch_assert.sv */
`timescale 1ns/1ps

module switch_assert (
	input logic                       i_clk,
	input logic                       i_reset,
	input eth_switch_pkg::port_mask_t o_tx_valid,
	input eth_switch_pkg::port_mask_t i_tx_ready,
	input eth_switch_pkg::beat_t      o_tx_data  [eth_switch_pkg::N_PORTS],
	input eth_switch_pkg::bytes_t     o_tx_bytes [eth_switch_pkg::N_PORTS],
	input eth_switch_pkg::port_mask_t o_tx_last
);
	import eth_switch_pkg::*;

	// A stalled beat holds until the sink takes it
	for (genvar p = 0; p < N_PORTS; p++) begin : g_hold
		a_tx_hold: assert property (@(posedge i_clk) disable iff (i_reset)
			o_tx_valid[p] && !i_tx_ready[p] |=> o_tx_valid[p] && $stable(o_tx_data[p])
				&& $stable(o_tx_bytes[p]) && $stable(o_tx_last[p]))
			else $error("Output %0d changed a stalled beat", p);
	end

	// Outputs stay quiet while in reset
	a_reset_quiet: assert property (@(posedge i_clk) i_reset |=> o_tx_valid == '0)
		else $error("o_tx_valid raised during reset");

endmodule

bind switch_top switch_assert switch_assert_i (.*);

/* tb_switch.sv */
`timescale 1ns/1ps

module tb_switch;
	import eth_switch_pkg::*;

	localparam int MAX_BEATS = 6;
	localparam int BURST_LEN = 8;
	localparam int TBL_N     = 2**LG_TBL;

	// One frame as sent with unused beats left at zero
	typedef struct packed {
		logic [2:0]            len;
		bytes_t                last_bytes;
		beat_t [MAX_BEATS-1:0] data;
	} frame_t;

	logic       i_clk;
	logic       i_reset;
	port_mask_t i_rx_valid, o_rx_ready, i_rx_last;
	beat_t      i_rx_data  [N_PORTS];
	bytes_t     i_rx_bytes [N_PORTS];
	port_mask_t o_tx_valid, i_tx_ready, o_tx_last;
	beat_t      o_tx_data  [N_PORTS];
	bytes_t     o_tx_bytes [N_PORTS];

	// Expected frames indexed by output * N_PORTS + source
	frame_t exp_q [N_PORTS*N_PORTS][$];
	frame_t burst [N_PORTS][BURST_LEN];
	frame_t rx_f  [N_PORTS];
	int     rx_len [N_PORTS] = '{default: 0};
	int     burst_src [N_PORTS] = '{4, 1, 0, 3};
	int     beats_sent = 0;
	logic   random_ready = 1'b0;
	logic [31:0] lfsr = 32'hf9ab;
	string  test_name = "none";

	// Reference copy of the route table
	mac_t              ref_mac  [TBL_N];
	port_id_t          ref_port [TBL_N];
	logic [TBL_N-1:0]  ref_vld = '0;
	logic [LG_TBL-1:0] ref_ptr = '0;

	switch_top switch_top_i (.*);

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic mac_t station_mac(input int k);
		return 48'h02_00_5e_10_00_00 + mac_t'(k);
	endfunction

	// Known destination goes to one port and an unknown one floods
	// A frame never goes back to its source port
	function automatic port_mask_t route_mask(input int src, input mac_t dst);
		port_mask_t m;
		m = '1;
		for (int e = 0; e < TBL_N; e++) begin
			if (ref_vld[e] && ref_mac[e] == dst)
				m = port_mask_t'(1) << ref_port[e];
		end
		return m & ~(port_mask_t'(1) << src);
	endfunction

	task ref_learn(input int port, input mac_t mac);
		logic hit;
		hit = 1'b0;
		for (int e = 0; e < TBL_N; e++) begin
			if (ref_vld[e] && ref_mac[e] == mac) begin
				ref_port[e] = port_id_t'(port);
				hit = 1'b1;
			end
		end
		if (!hit) begin
			ref_mac[ref_ptr]  = mac;
			ref_port[ref_ptr] = port_id_t'(port);
			ref_vld[ref_ptr]  = 1'b1;
			ref_ptr = ref_ptr + 1'b1;
		end
	endtask

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check(input string what, input logic [63:0] exp_v, input logic [63:0] act_v);
		if (exp_v !== act_v)
			fail_now($sformatf("ERROR %s %s expected %h actual %h",
				test_name, what, exp_v, act_v));
	endtask

	// Beat 1 carries the source port as a tag in bits 31..24
	function frame_t make_frame(input int src, input mac_t src_mac, input mac_t dst_mac);
		frame_t f;
		f = '0;
		f.len = 3'(2 + rand_bits(3) % 5);
		f.last_bytes = bytes_t'(rand_bits(3));
		f.data[0] = {dst_mac, src_mac[47:32]};
		f.data[1] = {src_mac[31:0], 8'(src), 24'(rand_bits(24))};
		for (int b = 2; b < int'(f.len); b++)
			f.data[b] = rand_bits(64);
		return f;
	endfunction

	task queue_frame(input int src, input frame_t f, input port_mask_t mask);
		for (int o = 0; o < N_PORTS; o++) begin
			if (mask[o])
				exp_q[o*N_PORTS + src].push_back(f);
		end
		beats_sent += int'(f.len);
	endtask

	function int pending_frames();
		int n;
		n = 0;
		for (int i = 0; i < N_PORTS*N_PORTS; i++)
			n += exp_q[i].size();
		return n;
	endfunction

	task automatic send_frame(input int port, input frame_t f);
		for (int b = 0; b < int'(f.len); b++) begin
			@(negedge i_clk);
			i_rx_valid[port] = 1'b1;
			i_rx_data[port]  = f.data[b];
			i_rx_bytes[port] = (b == int'(f.len) - 1) ? f.last_bytes : '0;
			i_rx_last[port]  = (b == int'(f.len) - 1);
			@(posedge i_clk);
			while (!o_rx_ready[port])
				@(posedge i_clk);
		end
		@(negedge i_clk);
		i_rx_valid[port] = 1'b0;
		i_rx_last[port]  = 1'b0;
	endtask

	task automatic send_burst(input int port);
		for (int k = 0; k < BURST_LEN; k++)
			send_frame(port, burst[port][k]);
	endtask

	task wait_drained();
		while (pending_frames() != 0)
			@(posedge i_clk);
	endtask

	// Send one frame from a station on a port and wait for its delivery
	task send_one(input int src, input int from_stn, input int to_stn);
		frame_t f;
		f = make_frame(src, station_mac(from_stn), station_mac(to_stn));
		queue_frame(src, f, route_mask(src, station_mac(to_stn)));
		ref_learn(src, station_mac(from_stn));
		send_frame(src, f);
		wait_drained();
	endtask

	////////////////////////////////////////////////////////////
	// Clock, sink ready, watchdog
	////////////////////////////////////////////////////////////

	initial begin : clock_gen
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	initial begin : ready_driver
		i_tx_ready = '1;
		forever begin
			@(negedge i_clk);
			if (random_ready)
				i_tx_ready = port_mask_t'(rand_bits(N_PORTS));
			else
				i_tx_ready = '1;
		end
	end

	// Limit grows with every beat queued
	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge i_clk);
			cycles++;
			if (cycles > 1000 + 40 * beats_sent)
				fail_now("Watchdog expired, the switch stopped delivering frames");
		end
	end

	////////////////////////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////////////////////////

	always @(posedge i_clk) begin : monitor
		int     src;
		frame_t exp_f;
		for (int o = 0; o < N_PORTS; o++) begin
			if (!i_reset && o_tx_valid[o] && i_tx_ready[o]) begin
				if (rx_len[o] == MAX_BEATS)
					fail_now($sformatf("Output %0d sent a frame that is too long", o));
				rx_f[o].data[rx_len[o]] = o_tx_data[o];
				rx_len[o]++;
				if (!o_tx_last[o]) begin
					check("bytes of inner beat", 64'd0, 64'(o_tx_bytes[o]));
				end else begin
					rx_f[o].len = 3'(rx_len[o]);
					rx_f[o].last_bytes = o_tx_bytes[o];
					rx_len[o] = 0;
					if (rx_f[o].len < 3'd2)
						fail_now($sformatf("Output %0d sent a frame of one beat", o));
					src = int'(rx_f[o].data[1][31:24]);
					if (src >= N_PORTS)
						fail_now($sformatf("Output %0d sent a frame with a bad tag", o));
					if (exp_q[o*N_PORTS + src].size() == 0)
						fail_now($sformatf("Output %0d sent an unexpected frame from port %0d",
							o, src));
					exp_f = exp_q[o*N_PORTS + src].pop_front();
					check("frame length", 64'(exp_f.len), 64'(rx_f[o].len));
					check("last bytes", 64'(exp_f.last_bytes), 64'(rx_f[o].last_bytes));
					for (int b = 0; b < int'(exp_f.len); b++)
						check($sformatf("output %0d beat %0d", o, b),
							exp_f.data[b], rx_f[o].data[b]);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	initial begin : main
		int dst;
		i_reset    = 1'b1;
		i_rx_valid = '0;
		i_rx_last  = '0;
		for (int p = 0; p < N_PORTS; p++) begin
			i_rx_data[p]  = '0;
			i_rx_bytes[p] = '0;
		end
		repeat (5) @(negedge i_clk);
		i_reset = 1'b0;
		@(negedge i_clk);
		test_name = "reset";
		check("tx valid", 64'd0, 64'(o_tx_valid));
		check("rx ready", 64'(port_mask_t'('1)), 64'(o_rx_ready));

		// Unknown destination floods while stations 0..3 get learned
		test_name = "flood";
		for (int p = 0; p < N_PORTS; p++)
			send_one(p, p, 7);

		test_name = "learned";
		send_one(1, 1, 0);
		send_one(3, 3, 2);
		send_one(0, 0, 3);

		// The flood behind the dropped frame proves it was drained
		test_name = "own port";
		send_one(0, 4, 0);
		send_one(0, 4, 6);

		test_name = "relearn";
		send_one(2, 0, 7);
		send_one(1, 1, 0);
		send_one(3, 3, 0);

		// Every source is already learned on its port so the table stays fixed
		test_name = "all ports";
		for (int p = 0; p < N_PORTS; p++) begin
			for (int k = 0; k < BURST_LEN; k++) begin
				dst = int'(rand_bits(3) % 6);
				if (dst == 5)
					dst = 7;
				burst[p][k] = make_frame(p, station_mac(burst_src[p]), station_mac(dst));
				queue_frame(p, burst[p][k], route_mask(p, station_mac(dst)));
				ref_learn(p, station_mac(burst_src[p]));
			end
		end
		random_ready = 1'b1;
		fork
			send_burst(0);
			send_burst(1);
			send_burst(2);
			send_burst(3);
		join
		wait_drained();
		random_ready = 1'b0;

		// No output may still be sending once the last expected frame is in
		@(negedge i_clk);
		test_name = "end";
		check("tx valid after drain", 64'd0, 64'(o_tx_valid));
		for (int o = 0; o < N_PORTS; o++)
			check($sformatf("output %0d partial frame beats", o), 64'd0, 64'(rx_len[o]));

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* filelist.f */
eth_switch_pkg.sv
rx_src_mac.sv
pkt_fifo.sv
route_table.sv
tx_dst_lookup.sv
tx_arbiter.sv
switch_top.sv
switch_assert.sv
tb_switch.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_switch -o sim_switch
./obj_dir/sim_switch > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation finished without failure"
